// ==== list.f ====
logic/sm83_pkg.sv
logic/sm83_decode.sv
logic/sm83_alu.sv
logic/sm83_core.sv
logic/work_ram.sv
logic/gb_soc_top.sv
sim/gb_soc_top_tb.sv

// ==== logic/gb_soc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_soc_top (
  input  logic        clk,
  input  logic        reset,
  input  logic        load_en,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data,
  output logic [15:0] addr_bus,
  output logic [7:0]  data_bus_mon,
  output logic        mem_read,
  output logic        mem_write
);

  wire [7:0] data_bus;   // Shared tri-state bus

  sm83_core core_inst (
    .clk       (clk),
    .reset     (reset),
    .addr_bus  (addr_bus),
    .data_bus  (data_bus),
    .mem_read  (mem_read),
    .mem_write (mem_write)
  );

  work_ram ram_inst (
    .clk       (clk),
    .addr_bus  (addr_bus),
    .data_bus  (data_bus),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data)
  );

  assign data_bus_mon = data_bus;

endmodule

`default_nettype wire

// ==== logic/sm83_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_alu (
  input  sm83_pkg::alu_op_t     alu_op,
  input  logic [7:0]            operand_a,
  input  logic [7:0]            operand_b,
  input  logic [3:0]            flags_in,   // Z N H C
  output sm83_pkg::alu_result_t result
);

  import sm83_pkg::*;

  always_comb begin
    logic [8:0] full;
    logic [4:0] half;
    logic [7:0] res;
    logic       n;
    logic       hc;
    logic       cy;
    full = 9'd0;
    half = 5'd0;
    res = operand_a;
    n = flags_in[2];
    hc = flags_in[1];
    cy = flags_in[0];

    case (alu_op)
      ALU_ADD: begin
        full = {1'b0, operand_a} + {1'b0, operand_b};
        half = {1'b0, operand_a[3:0]} + {1'b0, operand_b[3:0]};
        res = full[7:0];
        n = 1'b0;
        hc = half[4];
        cy = full[8];
      end
      ALU_SUB: begin
        full = {1'b0, operand_a} - {1'b0, operand_b};   // Bit 8 is the borrow
        half = {1'b0, operand_a[3:0]} - {1'b0, operand_b[3:0]};
        res = full[7:0];
        n = 1'b1;
        hc = half[4];
        cy = full[8];
      end
      ALU_AND: begin
        res = operand_a & operand_b;
        {n, hc, cy} = 3'b010;
      end
      ALU_XOR: begin
        res = operand_a ^ operand_b;
        {n, hc, cy} = 3'b000;
      end
      ALU_INC: begin
        res = operand_a + 8'd1;
        n = 1'b0;
        hc = (operand_a[3:0] == 4'hF);   // C is kept
      end
      ALU_DEC: begin
        res = operand_a - 8'd1;
        n = 1'b1;
        hc = (operand_a[3:0] == 4'h0);
      end
      ALU_MOV: res = operand_b;
      default: res = operand_a;   // Jumps are handled in the core
    endcase

    result.result = res;
    if (alu_op inside {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR, ALU_INC, ALU_DEC}) begin
      result.flags = {(res == 8'h00), n, hc, cy};
    end else begin
      result.flags = flags_in;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sm83_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_core (
  input  logic        clk,
  input  logic        reset,
  output logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  output logic        mem_read,
  output logic        mem_write
);

  import sm83_pkg::*;

  cpu_regs_t     regs;
  opcode_t       ir;
  logic [15:0]   wz;            // Temporary W:Z pair
  t_phase_t      t_phase;
  cycle_count_t  cycle_count;
  cycle_count_t  num_q;         // Length of the running instruction
  micro_cycle_t  step_q;        // Step latched at T1
  control_word_t control_word;
  alu_result_t   alu_out;
  logic [7:0]    alu_a;
  logic [7:0]    alu_b;
  logic [15:0]   idu_out;
  logic          drive_en;
  logic [7:0]    wdata;

  function automatic logic [15:0] get_pair(cpu_regs_t r, addr_src_t src);
    case (src)
      ADDR_SP: return r.sp;
      ADDR_HL: return {r.h, r.l};
      default: return r.pc;
    endcase
  endfunction

  function automatic cpu_regs_t set_pair(cpu_regs_t r, addr_src_t src, logic [15:0] val);
    cpu_regs_t n;
    n = r;
    case (src)
      ADDR_PC: n.pc = val;
      ADDR_SP: n.sp = val;
      ADDR_HL: {n.h, n.l} = val;
      default: n = r;
    endcase
    return n;
  endfunction

  function automatic logic [7:0] get_byte(cpu_regs_t r, reg_sel_t sel, logic [15:0] tmp);
    case (sel)
      A: return r.a;
      F: return r.flags;
      B: return r.b;
      C: return r.c;
      D: return r.d;
      E: return r.e;
      H: return r.h;
      L: return r.l;
      Z: return tmp[7:0];
      W: return tmp[15:8];
      default: return 8'h00;
    endcase
  endfunction

  function automatic cpu_regs_t set_byte(cpu_regs_t r, reg_sel_t sel, logic [7:0] val);
    cpu_regs_t n;
    n = r;
    case (sel)
      A: n.a = val;
      F: n.flags = {val[7:4], 4'h0};   // Low nibble reads as zero
      B: n.b = val;
      C: n.c = val;
      D: n.d = val;
      E: n.e = val;
      H: n.h = val;
      L: n.l = val;
      default: n = r;
    endcase
    return n;
  endfunction

  function automatic logic cond_met(cond_t cc, logic [3:0] f);
    case (cc)
      COND_NZ: return !f[3];
      COND_Z:  return f[3];
      COND_NC: return !f[0];
      COND_C:  return f[0];
      default: return 1'b1;
    endcase
  endfunction

  sm83_decode decode_inst (
    .ir           (ir),
    .control_word (control_word)
  );

  sm83_alu alu_inst (
    .alu_op    (step_q.alu_op),
    .operand_a (alu_a),
    .operand_b (alu_b),
    .flags_in  (regs.flags[7:4]),
    .result    (alu_out)
  );

  assign alu_a = get_byte(regs, step_q.alu_dst, wz);
  assign alu_b = get_byte(regs, step_q.alu_src, wz);
  assign idu_out = (step_q.idu_op == IDU_DEC) ? get_pair(regs, step_q.addr_src) - 16'd1
                                              : get_pair(regs, step_q.addr_src) + 16'd1;

  // Core drives only while writing, otherwise RAM may drive
  assign data_bus = drive_en ? wdata : 8'hzz;

  always_ff @(posedge clk or posedge reset) begin
    cpu_regs_t r;
    r = regs;
    if (reset) begin
      r = '0;
      r.sp = RESET_SP;
      regs <= r;
      ir.raw <= 8'h00;            // Starts as NOP, so first fetch is from 0
      t_phase <= T1;
      cycle_count <= '0;
      num_q <= 3'd1;
      step_q <= IDLE_STEP;
      addr_bus <= 16'h0000;
      mem_read <= 1'b0;
      mem_write <= 1'b0;
      drive_en <= 1'b0;
    end else begin
      case (t_phase)
        T1: begin
          step_q <= control_word.cycles[cycle_count];
          num_q <= control_word.num_cycles;
          if (control_word.cycles[cycle_count].addr_src != ADDR_NONE) begin
            addr_bus <= get_pair(regs, control_word.cycles[cycle_count].addr_src);
          end
          t_phase <= T2;
        end
        T2: begin
          mem_read <= (step_q.data_bus_op == DATA_BUS_OP_READ);
          mem_write <= (step_q.data_bus_op == DATA_BUS_OP_WRITE);
          drive_en <= (step_q.data_bus_op == DATA_BUS_OP_WRITE);
          wdata <= get_byte(regs, step_q.data_bus_src, wz);
          t_phase <= T3;
        end
        T3: begin
          if (step_q.data_bus_op == DATA_BUS_OP_READ) begin
            case (step_q.data_bus_src)
              IR: ir.raw <= data_bus;
              Z: wz[7:0] <= data_bus;
              W: wz[15:8] <= data_bus;
              default: r = set_byte(r, step_q.data_bus_src, data_bus);
            endcase
          end
          t_phase <= T4;
        end
        T4: begin
          if (step_q.idu_op != IDU_NONE) r = set_pair(r, step_q.addr_src, idu_out);
          case (step_q.alu_op)
            ALU_NOP: r = r;
            ALU_JUMP_WZ: r.pc = wz;
            ALU_REL_JUMP: r.pc = r.pc + {{8{wz[7]}}, wz[7:0]};
            ALU_MOV: r = set_byte(r, step_q.alu_dst, alu_out.result);
            default: begin
              r = set_byte(r, step_q.alu_dst, alu_out.result);
              r.flags = {alu_out.flags, 4'h0};
            end
          endcase
          mem_read <= 1'b0;
          mem_write <= 1'b0;
          drive_en <= 1'b0;
          // Failed condition skips straight to the shared fetch slot
          if (step_q.misc_op == MISC_COND_CHECK && !cond_met(step_q.cond, regs.flags[7:4]))
            cycle_count <= cycle_count_t'(MAX_CYCLES_PER_INSTR - 1);
          else if (cycle_count >= cycle_count_t'(num_q - 3'd1))
            cycle_count <= '0;
          else
            cycle_count <= cycle_count + 3'd1;
          t_phase <= T1;
        end
        default: t_phase <= T1;
      endcase
      regs <= r;
    end
  end

  a_one_strobe: assert property (@(posedge clk) disable iff (reset)
    !(mem_read && mem_write));
  a_drive_on_write: assert property (@(posedge clk) disable iff (reset)
    drive_en |-> mem_write);
  a_idle_at_t1: assert property (@(posedge clk) disable iff (reset)
    (t_phase == T1) |-> (!mem_read && !mem_write));
  a_flags_low_zero: assert property (@(posedge clk) disable iff (reset)
    regs.flags[3:0] == 4'h0);

endmodule

`default_nettype wire

// ==== logic/sm83_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module sm83_decode (
  input  sm83_pkg::opcode_t       ir,
  output sm83_pkg::control_word_t control_word
);

  import sm83_pkg::*;

  // Register field encoding, (HL) slot has no byte register
  function automatic reg_sel_t reg8(logic [2:0] idx);
    case (idx)
      3'd0: return B;
      3'd1: return C;
      3'd2: return D;
      3'd3: return E;
      3'd4: return H;
      3'd5: return L;
      3'd7: return A;
      default: return NONE;
    endcase
  endfunction

  function automatic alu_op_t alu_of(logic [2:0] y);
    case (y)
      3'd0: return ALU_ADD;
      3'd2: return ALU_SUB;
      3'd4: return ALU_AND;
      3'd5: return ALU_XOR;
      default: return ALU_NOP;   // ADC, SBC, OR, CP not handled
    endcase
  endfunction

  function automatic micro_cycle_t bus_step(addr_src_t addr, data_bus_op_t op,
                                            reg_sel_t sel, idu_op_t idu);
    micro_cycle_t s;
    s = IDLE_STEP;
    s.addr_src = addr;
    s.data_bus_op = op;
    s.data_bus_src = sel;
    s.idu_op = idu;
    return s;
  endfunction

  always_comb begin
    micro_cycle_t s;
    reg_sel_t     ry;
    reg_sel_t     rz;
    ry = reg8(ir.fields.y);
    rz = reg8(ir.fields.z);
    s = IDLE_STEP;
    control_word.num_cycles = 3'd1;
    // Every slot defaults to the fetch so the last step always lands on it
    for (int i = 0; i < MAX_CYCLES_PER_INSTR; i++) begin
      control_word.cycles[i] = FETCH_STEP;
    end

    case (ir.raw)
      8'hC3: begin  // JP nn
        control_word.num_cycles = 3'd4;
        control_word.cycles[0] = bus_step(ADDR_PC, DATA_BUS_OP_READ, Z, IDU_INC);
        control_word.cycles[1] = bus_step(ADDR_PC, DATA_BUS_OP_READ, W, IDU_INC);
        s.alu_op = ALU_JUMP_WZ;
        control_word.cycles[2] = s;
      end
      8'h20, 8'h28, 8'h30, 8'h38: begin  // JR cc,e
        control_word.num_cycles = 3'd3;
        s = bus_step(ADDR_PC, DATA_BUS_OP_READ, Z, IDU_INC);
        s.misc_op = MISC_COND_CHECK;
        s.cond = cond_t'({1'b0, ir.fields.y[1:0]});
        control_word.cycles[0] = s;
        s = IDLE_STEP;
        s.alu_op = ALU_REL_JUMP;
        control_word.cycles[1] = s;
      end
      8'hC5, 8'hF5: begin  // PUSH BC / PUSH AF, high byte first
        control_word.num_cycles = 3'd4;
        control_word.cycles[0] = bus_step(ADDR_SP, DATA_BUS_OP_ALU_ONLY, NONE, IDU_DEC);
        control_word.cycles[1] = bus_step(ADDR_SP, DATA_BUS_OP_WRITE,
                                          ir.raw[4] ? A : B, IDU_DEC);
        control_word.cycles[2] = bus_step(ADDR_SP, DATA_BUS_OP_WRITE,
                                          ir.raw[4] ? F : C, IDU_NONE);
      end
      8'h77: begin  // LD (HL),A
        control_word.num_cycles = 3'd2;
        control_word.cycles[0] = bus_step(ADDR_HL, DATA_BUS_OP_WRITE, A, IDU_NONE);
      end
      8'h7E: begin  // LD A,(HL)
        control_word.num_cycles = 3'd2;
        control_word.cycles[0] = bus_step(ADDR_HL, DATA_BUS_OP_READ, A, IDU_NONE);
      end
      default: begin
        if (ir.fields.x == 2'd0 && ry != NONE) begin
          if (ir.fields.z == 3'd6) begin  // LD r,n8
            control_word.num_cycles = 3'd2;
            control_word.cycles[0] = bus_step(ADDR_PC, DATA_BUS_OP_READ, ry, IDU_INC);
          end else if (ir.fields.z == 3'd4 || ir.fields.z == 3'd5) begin
            s = FETCH_STEP;  // INC/DEC overlap the fetch
            s.alu_op = ir.fields.z[0] ? ALU_DEC : ALU_INC;
            s.alu_dst = ry;
            s.alu_src = ry;
            control_word.cycles[0] = s;
          end
        end else if (ir.fields.x == 2'd2 && rz != NONE && alu_of(ir.fields.y) != ALU_NOP) begin
          s = FETCH_STEP;
          s.alu_op = alu_of(ir.fields.y);
          s.alu_dst = A;
          s.alu_src = rz;
          control_word.cycles[0] = s;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/sm83_pkg.sv ====
`default_nettype none

package sm83_pkg;

  localparam int MAX_CYCLES_PER_INSTR = 5;
  localparam int RAM_ADDR_BITS = 10;      // RAM mirrors across 64 KiB
  localparam logic [15:0] RESET_SP = 16'hFFFE;

  typedef logic [2:0] cycle_count_t;

  // Flags live in bits 7..4 as Z N H C
  typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  flags;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  d;
    logic [7:0]  e;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [15:0] pc;
    logic [15:0] sp;
  } cpu_regs_t;

  // Opcode seen as a plain byte or as the x/y/z split
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [1:0] x;
      logic [2:0] y;
      logic [2:0] z;
    } fields;
  } opcode_t;

  typedef enum logic [1:0] {T1, T2, T3, T4} t_phase_t;

  typedef enum logic [1:0] {ADDR_PC, ADDR_SP, ADDR_HL, ADDR_NONE} addr_src_t;

  typedef enum logic [1:0] {
    DATA_BUS_OP_READ,
    DATA_BUS_OP_WRITE,
    DATA_BUS_OP_ALU_ONLY
  } data_bus_op_t;

  typedef enum logic [3:0] {A, F, B, C, D, E, H, L, IR, Z, W, NONE} reg_sel_t;

  typedef enum logic [1:0] {IDU_NONE, IDU_INC, IDU_DEC} idu_op_t;

  typedef enum logic [3:0] {
    ALU_NOP,
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_XOR,
    ALU_INC,
    ALU_DEC,
    ALU_MOV,       // Copy only, flags untouched
    ALU_JUMP_WZ,   // pc <= W:Z
    ALU_REL_JUMP   // pc += signed Z
  } alu_op_t;

  typedef enum logic {MISC_NONE, MISC_COND_CHECK} misc_op_t;

  typedef enum logic [2:0] {COND_NZ, COND_Z, COND_NC, COND_C, COND_ALWAYS} cond_t;

  // One machine cycle of work
  typedef struct packed {
    addr_src_t    addr_src;
    data_bus_op_t data_bus_op;
    reg_sel_t     data_bus_src;
    idu_op_t      idu_op;
    alu_op_t      alu_op;
    reg_sel_t     alu_dst;
    reg_sel_t     alu_src;
    misc_op_t     misc_op;
    cond_t        cond;
  } micro_cycle_t;

  typedef struct packed {
    cycle_count_t num_cycles;
    micro_cycle_t [MAX_CYCLES_PER_INSTR-1:0] cycles;
  } control_word_t;

  typedef struct packed {
    logic [7:0] result;
    logic [3:0] flags;
  } alu_result_t;

  // Cycle with no bus traffic and no register change
  localparam micro_cycle_t IDLE_STEP = '{
    addr_src: ADDR_NONE, data_bus_op: DATA_BUS_OP_ALU_ONLY, data_bus_src: NONE,
    idu_op: IDU_NONE, alu_op: ALU_NOP, alu_dst: NONE, alu_src: NONE,
    misc_op: MISC_NONE, cond: COND_ALWAYS
  };

  // Opcode fetch that closes every instruction
  localparam micro_cycle_t FETCH_STEP = '{
    addr_src: ADDR_PC, data_bus_op: DATA_BUS_OP_READ, data_bus_src: IR,
    idu_op: IDU_INC, alu_op: ALU_NOP, alu_dst: NONE, alu_src: NONE,
    misc_op: MISC_NONE, cond: COND_ALWAYS
  };

endpackage

`default_nettype wire

// ==== logic/work_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module work_ram (
  input  logic        clk,
  input  logic [15:0] addr_bus,
  inout  wire  [7:0]  data_bus,
  input  logic        mem_read,
  input  logic        mem_write,
  input  logic        load_en,
  input  logic [15:0] load_addr,
  input  logic [7:0]  load_data
);

  import sm83_pkg::*;

  logic [7:0] mem [2**RAM_ADDR_BITS];
  logic [RAM_ADDR_BITS-1:0] bus_idx;    // Upper address bits ignored, RAM mirrors
  logic [RAM_ADDR_BITS-1:0] load_idx;

  assign bus_idx = addr_bus[RAM_ADDR_BITS-1:0];
  assign load_idx = load_addr[RAM_ADDR_BITS-1:0];

  // Read data straight from the array for the whole strobe
  assign data_bus = mem_read ? mem[bus_idx] : 8'hzz;

  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_idx] <= load_data;
    end else if (mem_write) begin
      mem[bus_idx] <= data_bus;   // Hit twice per write cycle, same byte
    end
  end

  // Loader only runs with the core held in reset
  a_no_load_collision: assert property (@(posedge clk)
    !(load_en && mem_write));

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator, pass only if the pass line shows up

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module gb_soc_top_tb -o gb_soc_top_tb_sim \
  && ./obj_dir/gb_soc_top_tb_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }

// ==== sim/gb_soc_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gb_soc_top_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 4;
  localparam int MAX_PROG = 256;
  localparam int MAX_WRITES = 64;
  // Register codes as in the opcode y/z fields
  localparam int R_B = 0;
  localparam int R_C = 1;
  localparam int R_H = 4;
  localparam int R_L = 5;
  localparam int R_A = 7;
  localparam int K_ADD = 0;   // ALU kinds, the first four match opcode y
  localparam int K_SUB = 2;
  localparam int K_AND = 4;
  localparam int K_XOR = 5;
  localparam int K_INC = 8;
  localparam int K_DEC = 9;
  localparam logic [7:0] POISON = 8'hEE;

  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;
  } bus_write_t;

  typedef struct packed {
    logic [7:0]  a;
    logic [7:0]  f;
    logic [7:0]  b;
    logic [7:0]  c;
    logic [7:0]  h;
    logic [7:0]  l;
    logic [15:0] pc;
    logic [15:0] sp;
  } model_regs_t;

  logic        clk;
  logic        reset;
  logic        load_en;
  logic [15:0] load_addr;
  logic [7:0]  load_data;
  logic [15:0] addr_bus;
  logic [7:0]  data_bus_mon;
  logic        mem_read;
  logic        mem_write;

  logic [7:0]  prog [MAX_PROG];
  bus_write_t  exp_writes [MAX_WRITES];
  logic [7:0]  model_mem [1024];     // RAM mirrors every 1 KiB
  model_regs_t m;
  int          prog_len;
  int          exp_count;
  int          exp_reads;
  int          exp_mcycles;
  logic [15:0] end_addr;
  integer      seed;
  int          error_count;
  int          write_count;
  int          read_count;
  int          reads_at_done;
  int          watchdog_clocks;
  bit          write_seen;
  bit          read_seen;
  bit          running;
  bit          done;
  time         last_read;

  gb_soc_top gb_soc_top_inst (
    .clk          (clk),
    .reset        (reset),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .addr_bus     (addr_bus),
    .data_bus_mon (data_bus_mon),
    .mem_read     (mem_read),
    .mem_write    (mem_write)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [7:0] get_reg(int idx);
    case (idx)
      R_B: return m.b;
      R_C: return m.c;
      R_H: return m.h;
      R_L: return m.l;
      R_A: return m.a;
      default: return 8'h00;
    endcase
  endfunction

  task automatic put_reg(input int idx, input logic [7:0] v);
    case (idx)
      R_B: m.b = v;
      R_C: m.c = v;
      R_H: m.h = v;
      R_L: m.l = v;
      R_A: m.a = v;
      default: m.a = m.a;
    endcase
  endtask

  // Returns {result, flags byte} with flags as Z N H C in bits 7..4
  function automatic logic [15:0] alu_model(int kind, logic [7:0] x, logic [7:0] y,
                                            logic [7:0] f_in);
    logic [7:0] res;
    logic       nf;
    logic       hf;
    logic       cf;
    res = x;
    nf = f_in[6];
    hf = f_in[5];
    cf = f_in[4];
    case (kind)
      K_ADD: begin
        res = x + y;
        nf = 1'b0;
        hf = (int'(x[3:0]) + int'(y[3:0])) > 15;
        cf = (int'(x) + int'(y)) > 255;
      end
      K_SUB: begin
        res = x - y;
        nf = 1'b1;
        hf = x[3:0] < y[3:0];
        cf = x < y;
      end
      K_AND: begin
        res = x & y;
        {nf, hf, cf} = 3'b010;
      end
      K_XOR: begin
        res = x ^ y;
        {nf, hf, cf} = 3'b000;
      end
      K_INC: begin
        res = x + 8'd1;
        nf = 1'b0;
        hf = (x[3:0] == 4'hF);   // Carry untouched
      end
      K_DEC: begin
        res = x - 8'd1;
        nf = 1'b1;
        hf = (x[3:0] == 4'h0);
      end
      default: res = x;
    endcase
    return {res, (res == 8'h00), nf, hf, cf, 4'h0};
  endfunction

  task automatic place_byte(input logic [15:0] addr, input logic [7:0] b);
    prog[addr[7:0]] = b;
    if (int'(addr) >= prog_len) prog_len = int'(addr) + 1;
  endtask

  task automatic emit_byte(input logic [7:0] b);
    place_byte(m.pc, b);
    m.pc = m.pc + 16'd1;
  endtask

  task automatic count_cost(input int reads, input int cycles);
    exp_reads += reads;
    exp_mcycles += cycles;
  endtask

  task automatic expect_write(input logic [15:0] addr, input logic [7:0] data);
    exp_writes[exp_count] = '{addr: addr, data: data};
    model_mem[addr[9:0]] = data;
    exp_count++;
  endtask

  task automatic op_nop;
    emit_byte(8'h00);
    count_cost(1, 1);
  endtask

  task automatic op_ld_imm(input int r, input logic [7:0] v);
    emit_byte(8'h06 | 8'(r << 3));
    emit_byte(v);
    put_reg(r, v);
    count_cost(2, 2);
  endtask

  task automatic op_store_hl;
    emit_byte(8'h77);
    expect_write({m.h, m.l}, m.a);
    count_cost(1, 2);
  endtask

  task automatic op_load_hl;
    emit_byte(8'h7E);
    m.a = model_mem[{m.h[1:0], m.l}];
    count_cost(2, 2);
  endtask

  task automatic op_alu(input int kind, input int src);
    logic [15:0] out;
    emit_byte(8'h80 | 8'(kind << 3) | 8'(src));
    out = alu_model(kind, m.a, get_reg(src), m.f);
    m.a = out[15:8];
    m.f = out[7:0];
    count_cost(1, 1);
  endtask

  task automatic op_incdec(input int r, input bit dec);
    logic [15:0] out;
    emit_byte(8'h04 | 8'(r << 3) | (dec ? 8'h01 : 8'h00));
    out = alu_model(dec ? K_DEC : K_INC, get_reg(r), 8'h00, m.f);
    put_reg(r, out[15:8]);
    m.f = out[7:0];
    count_cost(1, 1);
  endtask

  task automatic op_push(input bit af);
    emit_byte(af ? 8'hF5 : 8'hC5);
    m.sp = m.sp - 16'd1;
    expect_write(m.sp, af ? m.a : m.b);   // High byte first
    m.sp = m.sp - 16'd1;
    expect_write(m.sp, af ? m.f : m.c);
    count_cost(1, 4);
  endtask

  task automatic op_jp(input logic [15:0] target);
    emit_byte(8'hC3);
    emit_byte(target[7:0]);
    emit_byte(target[15:8]);
    m.pc = target;
    count_cost(3, 4);
  endtask

  task automatic op_jr_nz(input logic [15:0] target, output bit taken);
    logic [15:0] next;
    next = m.pc + 16'd2;
    emit_byte(8'h20);
    emit_byte(8'(target - next));
    taken = !m.f[7];
    if (taken) m.pc = target;
    count_cost(2, taken ? 3 : 2);
  endtask

  // Assembles the program and the expected writes in execution order
  task automatic build_program;
    int          kinds [6];
    bit          taken;
    logic [15:0] loop_addr;
    logic [15:0] skip_addr;
    kinds = '{K_ADD, K_SUB, K_AND, K_XOR, K_INC, K_DEC};
    m = '0;
    m.sp = 16'hFFFE;
    prog_len = 0;
    exp_count = 0;
    exp_reads = 1;                    // Reset NOP fetches address 0
    exp_mcycles = 1;
    repeat (3) op_nop();
    op_ld_imm(R_H, 8'h03);
    op_ld_imm(R_L, 8'h00);
    op_ld_imm(R_A, 8'hA5);
    op_store_hl();
    op_ld_imm(R_A, 8'h00);
    op_load_hl();
    op_incdec(R_L, 1'b0);
    op_store_hl();
    for (int round = 0; round < 2; round++) begin
      foreach (kinds[k]) begin
        op_ld_imm(R_A, 8'($random(seed)));
        if (kinds[k] == K_INC || kinds[k] == K_DEC) begin
          op_incdec(R_A, kinds[k] == K_DEC);
        end else begin
          op_ld_imm(R_B, 8'($random(seed)));
          op_alu(kinds[k], R_B);
        end
        op_store_hl();
        op_push(1'b1);
      end
    end
    op_ld_imm(R_B, 8'd4);             // Loop count
    op_ld_imm(R_A, 8'h40);
    loop_addr = m.pc;
    taken = 1'b1;
    while (taken) begin
      op_incdec(R_A, 1'b0);
      op_store_hl();
      op_incdec(R_B, 1'b1);
      op_jr_nz(loop_addr, taken);
    end
    op_ld_imm(R_A, 8'h5A);
    op_store_hl();
    skip_addr = m.pc + 16'd3;
    op_jp(skip_addr + 16'd3);
    place_byte(skip_addr, 8'h3E);     // Skipped LD A,n8 / LD (HL),A
    place_byte(skip_addr + 16'd1, POISON);
    place_byte(skip_addr + 16'd2, 8'h77);
    op_ld_imm(R_A, 8'h77);
    op_store_hl();
    op_ld_imm(R_B, 8'hB1);
    op_ld_imm(R_C, 8'hC2);
    op_push(1'b0);
    op_incdec(R_B, 1'b0);
    op_push(1'b0);
    end_addr = m.pc;                  // JP to itself parks the core
    emit_byte(8'hC3);
    emit_byte(end_addr[7:0]);
    emit_byte(end_addr[15:8]);
  endtask

  task automatic check_strobes_idle(input string when);
    assert (!mem_read && !mem_write) else begin
      error_count++;
      $display("[ERROR] %t: bus strobes active %s", $time, when);
    end
  endtask

  task automatic check_write;
    bus_write_t want;
    assert (write_count < exp_count) else begin
      error_count++;
      $display("[ERROR] %t: extra write of %h to %h", $time, data_bus_mon, addr_bus);
    end
    if (write_count < exp_count) begin
      want = exp_writes[write_count];
      assert (addr_bus == want.addr && data_bus_mon == want.data) else begin
        error_count++;
        $display("[ERROR] %t: write %0d is %h at %h, expected %h at %h", $time,
                 write_count, data_bus_mon, addr_bus, want.data, want.addr);
      end
    end
    write_count++;
  endtask

  task automatic record_read;
    if (read_count < 4) begin
      assert (addr_bus == 16'(read_count)) else begin
        error_count++;
        $display("[ERROR] %t: fetch %0d from %h, expected %h", $time, read_count,
                 addr_bus, 16'(read_count));
      end
      if (read_count > 0) begin
        assert ($time - last_read == 4 * CLK_PERIOD) else begin
          error_count++;
          $display("[ERROR] %t: NOP fetches %0t apart", $time, $time - last_read);
        end
      end
    end
    last_read = $time;
    read_count++;
    if (addr_bus == end_addr && !done) begin
      reads_at_done = read_count;
      done = 1'b1;
    end
  endtask

  // One check per strobe pulse, on its first low phase
  always @(negedge clk) begin
    if (!reset && mem_write && !write_seen) check_write();
    if (!reset && mem_read && !read_seen) record_read();
    write_seen = mem_write;
    read_seen = mem_read;
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    load_en = 1'b0;
    load_addr = 16'h0000;
    load_data = 8'h00;
    seed = 32'h5157;
    error_count = 0;
    write_count = 0;
    read_count = 0;
    reads_at_done = 0;
    running = 1'b0;
    done = 1'b0;
    $timeformat(-9, 0, " ns", 1);
    build_program();
    watchdog_clocks = (4 * exp_mcycles * 3) / 2;
    for (int i = 0; i < prog_len; i++) begin
      @(negedge clk);
      load_en = 1'b1;
      load_addr = 16'(i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_en = 1'b0;
    repeat (RESET_CYCLES - 1) @(negedge clk);
    check_strobes_idle("during reset");
    reset = 1'b0;
    running = 1'b1;
    @(negedge clk);
    check_strobes_idle("right after reset");
    wait (done);
    assert (write_count == exp_count) else begin
      error_count++;
      $display("[ERROR] %t: %0d writes seen, expected %0d", $time, write_count, exp_count);
    end
    assert (reads_at_done == exp_reads) else begin
      error_count++;
      $display("[ERROR] %t: %0d reads seen, expected %0d", $time, reads_at_done, exp_reads);
    end
    $display("Writes %0d of %0d, reads %0d of %0d, errors %0d", write_count, exp_count,
             reads_at_done, exp_reads, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    wait (running);
    repeat (watchdog_clocks) @(posedge clk);
    if (!done) begin
      $display("Timeout: program never finished in %0d clocks, writes %0d, reads %0d, errors %0d",
               watchdog_clocks, write_count, read_count, error_count);
      $display("ERRORS FOUND");
      $finish;
    end
  end

endmodule

`default_nettype wire
